// File: src.f
+incdir+test
design/rv_core_pkg.sv
design/stage_if.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core_top.sv
test/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f design/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

# The run passes only if the testbench printed the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: test/tb_reference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// Instruction words and console words
typedef logic [31:0] instr_q_t[$];
typedef logic [63:0] word_q_t[$];

// Runs a program from the reset state, returns the console words in order
function automatic word_q_t ref_console(input instr_q_t prog, input int ram_words);
    logic [63:0] x [32];
    // Sparse RAM, keyed by word index inside the window
    logic [63:0] mem [logic [63:0]];
    word_q_t     words;
    logic [31:0] w;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] ea;
    logic [63:0] res;
    logic [63:0] ram_end;
    logic        wr;
    ram_end = RAM_BASE + (64'(ram_words) << 3);
    for (int r = 0; r < 32; r++) begin
        x[r] = '0;
    end
    foreach (prog[n]) begin
        w     = prog[n];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        wr    = 1'b0;
        res   = '0;
        // Opcode and funct fields must all match, anything else does nothing
        if (w[6:0] == 7'b0110111) begin
            wr  = 1'b1;
            res = {{32{w[31]}}, w[31:12], 12'h000};
        end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            wr  = 1'b1;
            res = x[w[19:15]] + imm_i;
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
            wr  = 1'b1;
            res = x[w[19:15]] + x[w[24:20]];
        end else if (w[6:0] == 7'b0000011 && w[14:12] == 3'b011) begin
            // LD, zero outside the RAM window
            ea = x[w[19:15]] + imm_i;
            wr = 1'b1;
            if (ea >= RAM_BASE && ea < ram_end && mem.exists((ea - RAM_BASE) >> 3)) begin
                res = mem[(ea - RAM_BASE) >> 3];
            end
        end else if (w[6:0] == 7'b0100011 && w[14:12] == 3'b011) begin
            // SD, console or RAM, dropped elsewhere
            ea = x[w[19:15]] + imm_s;
            if (ea == CONSOLE_ADDR) begin
                words.push_back(x[w[24:20]]);
            end else if (ea >= RAM_BASE && ea < ram_end) begin
                mem[(ea - RAM_BASE) >> 3] = x[w[24:20]];
            end
        end
        // x0 stays zero
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;
        end
    end
    return words;
endfunction

`endif

// File: test/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_core_pkg::*;

    `include "tb_reference.svh"

    localparam int RAM_WORDS = 1024;
    // Test sizes
    localparam int G1 = 24;
    localparam int S2 = 8;
    localparam int U3 = 6;
    localparam int G4 = 16;
    localparam int K5 = 8;
    // Instructions plus key events over the whole run
    localparam int ITEMS = (2 * G1 + 5) + (3 * S2 + 9) + (U3 + 9) + 2 * G4 + K5;
    localparam int CYCLE_LIMIT = 40 * ITEMS + 200;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instr_valid;
    wire         instr_ready;
    logic [7:0]  key_code;
    logic        key_valid;
    wire         key_ready;
    wire  [63:0] console_data;
    wire         console_valid;
    logic        console_ready;
    // Random console stall enable
    logic        bp_on;
    // key_ready at the previous falling edge
    logic        key_ready_q;
    int          errors;
    int          checks;
    int          cycles;
    int          key_count;
    // Console words already taken from the reference
    int          n_exp;
    logic [63:0] expect_q[$];
    logic [31:0] all_prog[$];
    logic [31:0] batch[$];

    rv_core_top i_rv_core_top (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .key_code      (key_code),
        .key_valid     (key_valid),
        .key_ready     (key_ready),
        .console_data  (console_data),
        .console_valid (console_valid),
        .console_ready (console_ready)
    );

    always #50 clk = ~clk;

    // Console sink that stalls at random when enabled
    always @(posedge clk) begin
        #5;
        console_ready = bp_on ? 1'($urandom % 2) : 1'b1;
    end

    // Compare at the falling edge where handshake signals are settled
    always @(negedge clk) begin
        if (reset && console_valid && console_ready) begin
            if (expect_q.size() == 0) begin
                $display("Unexpected console word 0x%h with nothing left to expect",
                         console_data);
                errors++;
            end else begin
                check_value("console_data", console_data, expect_q.pop_front());
            end
        end
        // Each rise of key_ready counts once
        if (reset && key_ready && !key_ready_q) begin
            key_count++;
        end
        key_ready_q = key_ready;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    // RV64 encodings of the subset
    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    // Called at rising edge plus 5 ns and returns there after the transfer
    task automatic send_instr(input logic [31:0] word);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        instr_valid = 1'b0;
    endtask

    task automatic send_key(input logic [7:0] code);
        key_code  = code;
        key_valid = 1'b1;
        @(negedge clk);
        while (!key_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        key_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    // Random ALU op on x0..x7 followed by a console store of its destination
    task automatic queue_alu_pair();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        case ($urandom % 3)
            0: batch.push_back(lui_word(rd, 20'($urandom)));
            1: batch.push_back(addi_word(rd, rs1, 12'($urandom)));
            default: batch.push_back(add_word(rd, rs1, rs2));
        endcase
        batch.push_back(sd_word(rd, 5'd31, 12'h000));
    endtask

    // Reference reruns the whole program and only new words are expected
    task automatic run_batch();
        word_q_t want;
        foreach (batch[i]) begin
            all_prog.push_back(batch[i]);
        end
        want = ref_console(all_prog, RAM_WORDS);
        for (int i = n_exp; i < want.size(); i++) begin
            expect_q.push_back(want[i]);
        end
        n_exp = want.size();
        foreach (batch[i]) begin
            send_instr(batch[i]);
        end
        batch.delete();
        wait_drained();
    endtask

    task automatic alu_results();
        int start_errors;
        start_errors = errors;
        // x31 holds the console address and x30 the RAM base
        batch.push_back(lui_word(5'd31, 20'h40000));
        batch.push_back(add_word(5'd31, 5'd31, 5'd31));
        batch.push_back(lui_word(5'd30, 20'h00001));
        batch.push_back(addi_word(5'd0, 5'd0, 12'h005));
        batch.push_back(sd_word(5'd0, 5'd31, 12'h000));
        for (int g = 0; g < G1; g++) begin
            queue_alu_pair();
        end
        run_batch();
        report_test("alu", start_errors);
    endtask

    task automatic ram_round_trip();
        int          start_errors;
        logic [11:0] offs [S2];
        start_errors = errors;
        for (int i = 0; i < S2; i++) begin
            offs[i] = 12'(8 * ($urandom % 256));
            batch.push_back(sd_word(5'(1 + $urandom % 7), 5'd30, offs[i]));
        end
        for (int i = 0; i < S2; i++) begin
            batch.push_back(ld_word(5'(8 + i), 5'd30, offs[i]));
            batch.push_back(sd_word(5'(8 + i), 5'd31, 12'h000));
        end
        // Loaded value used by the very next op
        batch.push_back(ld_word(5'd20, 5'd30, offs[0]));
        batch.push_back(addi_word(5'd21, 5'd20, 12'h001));
        batch.push_back(sd_word(5'd21, 5'd31, 12'h000));
        // Nonzero targets so that only the loads can clear them
        batch.push_back(addi_word(5'd22, 5'd0, 12'h7ff));
        batch.push_back(addi_word(5'd23, 5'd0, 12'h7ff));
        // Loads just below the window and from the console address
        batch.push_back(ld_word(5'd22, 5'd30, 12'hff8));
        batch.push_back(ld_word(5'd23, 5'd31, 12'h000));
        batch.push_back(sd_word(5'd22, 5'd31, 12'h000));
        batch.push_back(sd_word(5'd23, 5'd31, 12'h000));
        run_batch();
        report_test("ram", start_errors);
    endtask

    task automatic ignored_ops();
        int          start_errors;
        logic [31:0] word;
        start_errors = errors;
        batch.push_back(sd_word(5'd3, 5'd30, 12'h000));
        // No device at 0x8000_0008 or 0xff0
        batch.push_back(sd_word(5'd1, 5'd31, 12'h008));
        batch.push_back(sd_word(5'd2, 5'd30, 12'hff0));
        for (int i = 0; i < U3; i++) begin
            word = $urandom;
            case (i % 3)
                // JAL
                0: word[6:0] = 7'b1101111;
                // SLTI
                1: begin
                    word[6:0]   = 7'b0010011;
                    word[14:12] = 3'b010;
                end
                // LW is not a doubleword load
                default: begin
                    word[6:0]   = 7'b0000011;
                    word[14:12] = 3'b010;
                end
            endcase
            batch.push_back(word);
        end
        for (int r = 1; r <= 4; r++) begin
            batch.push_back(sd_word(5'(r), 5'd31, 12'h000));
        end
        batch.push_back(ld_word(5'd24, 5'd30, 12'h000));
        batch.push_back(sd_word(5'd24, 5'd31, 12'h000));
        run_batch();
        report_test("ignored", start_errors);
    endtask

    task automatic console_stalls();
        int start_errors;
        start_errors = errors;
        bp_on = 1'b1;
        for (int g = 0; g < G4; g++) begin
            queue_alu_pair();
        end
        run_batch();
        bp_on = 1'b0;
        report_test("backpressure", start_errors);
    endtask

    task automatic key_echo();
        int         start_errors;
        logic [7:0] code;
        start_errors = errors;
        for (int k = 0; k < K5; k++) begin
            code = 8'($urandom);
            expect_q.push_back({56'b0, code});
            send_key(code);
        end
        wait_drained();
        check_value("key_ready rises", 64'(key_count), 64'(K5));
        report_test("keys", start_errors);
    endtask

    initial begin
        void'($urandom(12));
        clk           = 1'b0;
        reset         = 1'b0;
        instr         = '0;
        instr_valid   = 1'b0;
        key_code      = '0;
        key_valid     = 1'b0;
        console_ready = 1'b1;
        bp_on         = 1'b0;
        key_ready_q   = 1'b0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        key_count     = 0;
        n_exp         = 0;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b1;
        @(posedge clk);
        #5;
        alu_results();
        ram_round_trip();
        ignored_ops();
        console_stalls();
        key_echo();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
`default_nettype none

module rv_core_top #(
    parameter int RAM_WORDS = 1024
) (
    input  wire                          clk,
    input  wire                          reset,
    // Instruction stream
    input  wire [31:0]                   instr,
    input  wire                          instr_valid,
    output wire                          instr_ready,
    // Keyboard events, already decoded
    input  wire [7:0]                    key_code,
    input  wire                          key_valid,
    output wire                          key_ready,
    // Console output
    output wire [rv_core_pkg::XLEN-1:0]  console_data,
    output wire                          console_valid,
    input  wire                          console_ready
);

    import rv_core_pkg::*;

    wire            wb_en;
    wire [4:0]      wb_rd;
    wire [XLEN-1:0] wb_data;

    // Decode to execute
    stage_if #(.payload_t(dec_op_t)) dec_link (.clk(clk), .reset(reset));
    // Execute to memory
    stage_if #(.payload_t(mem_op_t)) mem_link (.clk(clk), .reset(reset));

    rv_decode i_rv_decode (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .out         (dec_link)
    );

    rv_execute i_rv_execute (
        .clk     (clk),
        .reset   (reset),
        .in      (dec_link),
        .out     (mem_link),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    rv_memory #(
        .RAM_WORDS (RAM_WORDS)
    ) i_rv_memory (
        .clk           (clk),
        .reset         (reset),
        .in            (mem_link),
        .key_code      (key_code),
        .key_valid     (key_valid),
        .key_ready     (key_ready),
        .console_data  (console_data),
        .console_valid (console_valid),
        .console_ready (console_ready),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

// File: design/rv_memory.sv
`default_nettype none

module rv_memory #(
    parameter int RAM_WORDS = 1024
) (
    input  wire                          clk,
    input  wire                          reset,
    stage_if.sink                        in,
    input  wire [7:0]                    key_code,
    input  wire                          key_valid,
    output logic                         key_ready,
    output logic [rv_core_pkg::XLEN-1:0] console_data,
    output logic                         console_valid,
    input  wire                          console_ready,
    output logic                         wb_en,
    output logic [4:0]                   wb_rd,
    output logic [rv_core_pkg::XLEN-1:0] wb_data
);

    import rv_core_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);
    // First address past the RAM window
    localparam logic [XLEN-1:0] RAM_LIMIT = RAM_BASE + (XLEN'(RAM_WORDS) << 3);

    logic [XLEN-1:0] ram [RAM_WORDS];
    logic [XLEN-1:0] ram_q;
    logic [XLEN-1:0] offset;
    logic [AW-1:0]   ram_idx;
    logic            in_ram;
    logic            is_console;
    logic            take;
    logic            key_take;
    logic            con_load;
    logic            ld_hit;
    mem_op_t         op;

    assign op = in.payload;

    // Address decode
    assign in_ram     = (op.addr >= RAM_BASE) && (op.addr < RAM_LIMIT);
    assign is_console = (op.addr == CONSOLE_ADDR);
    assign offset     = op.addr - RAM_BASE;
    // Word index without the byte offset
    assign ram_idx    = offset[AW+2:3];

    // Stalls while a console word is stuck
    assign in.ready = !console_valid || console_ready;
    assign take     = in.valid && in.ready;

    // Echo only with nothing in flight here
    assign key_ready = key_valid && !in.valid && !console_valid && !wb_en;
    assign key_take  = key_valid && key_ready;

    assign con_load = (take && op.kind == OP_SD && is_console) || key_take;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            console_valid <= 1'b0;
        end else if (con_load) begin
            console_valid <= 1'b1;
        end else if (console_ready) begin
            console_valid <= 1'b0;
        end
    end

    // Console word with key codes zero extended
    always_ff @(posedge clk) begin
        if (key_take) begin
            console_data <= {{(XLEN-8){1'b0}}, key_code};
        end else if (con_load) begin
            console_data <= op.data;
        end
    end

    // Data RAM with write and synchronous read
    always_ff @(posedge clk) begin
        if (take && in_ram) begin
            if (op.kind == OP_SD) begin
                ram[ram_idx] <= op.data;
            end else begin
                ram_q <= ram[ram_idx];
            end
        end
    end

    // One writeback pulse per load
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb_en  <= 1'b0;
            ld_hit <= 1'b0;
        end else begin
            wb_en  <= take && (op.kind == OP_LD);
            ld_hit <= take && (op.kind == OP_LD) && in_ram;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_rd <= op.rd;
        end
    end

    // Loads outside the window read zero
    assign wb_data = ld_hit ? ram_q : '0;

    a_console_hold: assert property (
        @(posedge clk) disable iff (!reset)
        console_valid && !console_ready |=> console_valid && $stable(console_data)
    );

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none

module rv_execute (
    input  wire                          clk,
    input  wire                          reset,
    stage_if.sink                        in,
    stage_if.source                      out,
    input  wire                          wb_en,
    input  wire [4:0]                    wb_rd,
    input  wire [rv_core_pkg::XLEN-1:0]  wb_data
);

    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_res;
    logic            alu_wr;
    logic            is_mem;
    logic            take;
    logic            out_fire;
    logic            ld_busy;
    logic            ld_on_out;
    dec_op_t         op;

    assign op = in.payload;

    // Operand read, x0 is never written so it stays zero
    assign rs1_val = regs[op.rs1];
    assign rs2_val = regs[op.rs2];

    // Load still waiting on the link to memory
    assign ld_on_out = out.valid && (out.payload.kind == OP_LD);
    assign out_fire  = out.valid && out.ready;

    // Interlock keeps register writes in program order
    assign in.ready = (!out.valid || out.ready) && !ld_busy && !ld_on_out;
    assign take     = in.valid && in.ready;

    assign is_mem = (op.kind == OP_LD) || (op.kind == OP_SD);

    always_comb begin
        alu_wr  = 1'b0;
        alu_res = '0;
        case (op.kind)
            OP_LUI: begin
                alu_wr  = 1'b1;
                alu_res = op.imm;
            end
            OP_ADDI: begin
                alu_wr  = 1'b1;
                alu_res = rs1_val + op.imm;
            end
            OP_ADD: begin
                alu_wr  = 1'b1;
                alu_res = rs1_val + rs2_val;
            end
            default: begin
                alu_wr = 1'b0;
            end
        endcase
    end

    // Register file, loads and ALU results never land on the same edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end else if (take && alu_wr && op.rd != 5'd0) begin
            regs[op.rd] <= alu_res;
        end
    end

    // Set once a load leaves, cleared by its writeback
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ld_busy <= 1'b0;
        end else if (out_fire && out.payload.kind == OP_LD) begin
            ld_busy <= 1'b1;
        end else if (wb_en) begin
            ld_busy <= 1'b0;
        end
    end

    // Only memory ops continue downstream
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out.valid <= 1'b0;
        end else if (take && is_mem) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // Effective address and store data
    always_ff @(posedge clk) begin
        if (take && is_mem) begin
            out.payload.kind <= op.kind;
            out.payload.rd   <= op.rd;
            out.payload.addr <= rs1_val + op.imm;
            out.payload.data <= rs2_val;
        end
    end

    // A writeback only comes back for a load this stage sent
    a_wb_after_load: assert property (
        @(posedge clk) disable iff (!reset)
        wb_en |-> ld_busy
    );

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`default_nettype none

module rv_decode (
    input  wire        clk,
    input  wire        reset,
    input  wire [31:0] instr,
    input  wire        instr_valid,
    output logic       instr_ready,
    stage_if.source    out
);

    import rv_core_pkg::*;

    logic    run;
    logic    take;
    dec_op_t dec;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Held off until the first clock after reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // One entry stage, free when empty or being drained
    assign instr_ready = run && (!out.valid || out.ready);
    assign take        = instr_valid && instr_ready;

    always_comb begin
        dec.kind = OP_NOP;
        dec.rd   = instr[11:7];
        dec.rs1  = instr[19:15];
        dec.rs2  = instr[24:20];
        dec.imm  = '0;
        case (opcode)
            OPC_LUI: begin
                // U format, upper 20 bits, sign extended to 64
                dec.kind = OP_LUI;
                dec.imm  = {{32{instr[31]}}, instr[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    dec.kind = OP_ADDI;
                    dec.imm  = {{52{instr[31]}}, instr[31:20]};
                end
            end
            OPC_OP: begin
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    dec.kind = OP_ADD;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_DW) begin
                    dec.kind = OP_LD;
                    dec.imm  = {{52{instr[31]}}, instr[31:20]};
                end
            end
            OPC_STORE: begin
                // S format, offset split around rd field
                if (funct3 == F3_DW) begin
                    dec.kind = OP_SD;
                    dec.imm  = {{52{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            default: begin
                // Anything else falls through as NOP
                dec.kind = OP_NOP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out.valid <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (take) begin
            out.payload <= dec;
        end
    end

endmodule

`default_nettype wire

// File: design/stage_if.sv
`default_nettype none

// Valid/ready link between two pipeline stages
interface stage_if #(
    parameter type payload_t = logic
) (
    input wire clk,
    input wire reset
);

    logic     valid;
    logic     ready;
    payload_t payload;

    modport source (output valid, output payload, input ready);
    modport sink (input valid, input payload, output ready);

    // Offered op must wait unchanged until the sink takes it
    a_hold_until_taken: assert property (
        @(posedge clk) disable iff (!reset)
        valid && !ready |=> valid && $stable(payload)
    );

endinterface

`default_nettype wire

// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // Integer register and data path width
    localparam int XLEN = 64;

    // Address map
    // Data RAM window starts here, its size is set by RAM_WORDS
    localparam logic [XLEN-1:0] RAM_BASE     = 64'h0000_0000_0000_1000;
    // Single console data register
    localparam logic [XLEN-1:0] CONSOLE_ADDR = 64'h0000_0000_8000_0000;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct fields
    localparam logic [2:0] F3_ADD = 3'b000;
    // Doubleword width for LD and SD
    localparam logic [2:0] F3_DW  = 3'b011;
    localparam logic [6:0] F7_ADD = 7'b0000000;

    // Operation class after decode
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_LUI  = 3'd1,
        OP_ADDI = 3'd2,
        OP_ADD  = 3'd3,
        OP_LD   = 3'd4,
        OP_SD   = 3'd5
    } op_kind_t;

    // Decode to execute
    typedef struct packed {
        op_kind_t        kind;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        // Already sign extended for its format
        logic [XLEN-1:0] imm;
    } dec_op_t;

    // Execute to memory, only LD and SD travel here
    typedef struct packed {
        op_kind_t        kind;
        logic [4:0]      rd;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } mem_op_t;

endpackage

`default_nettype wire
